/* Makefile */
# Verilator build of the fetch front end testbench

VERILATOR ?= verilator
TOP       ?= fetch_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Simulation finished: PASS

SOURCES := $(wildcard hdl/*.sv tests/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# pass only if the pass line shows up in the simulation output
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* hdl/fetch_controller.sv */
`timescale 1ns/100ps

module fetch_controller (
  input  logic clock,
  input  logic reset,

  // upstream handshake, from the pc stage
  input  logic valid_pre_i,
  output logic ready_pre_o,

  // downstream handshake, to predecode
  output logic valid_post_o,
  input  logic ready_post_i,

  // register enables for the datapath
  output logic pc_we_o,
  output logic inst_we_o,

  // address read channel
  input  logic arready_i,
  output logic arvalid_o,

  // read data channel
  output logic rready_o,
  input  logic rvalid_i
);

  import fetch_pkg::*;

  fetch_state_t cur_state;
  fetch_state_t next_state;

  // ********************
  // outputs
  // ********************

  // all handshake outputs come straight from the state
  assign ready_pre_o  = (cur_state == idle);
  assign arvalid_o    = (cur_state == wait_arready);
  assign rready_o     = (cur_state == wait_rvalid);
  assign valid_post_o = (cur_state == wait_ready);

  // capture strobes
  // pc on the upstream transfer
  assign pc_we_o   = valid_pre_i && ready_pre_o;
  // instruction word on the read data transfer
  assign inst_we_o = rvalid_i && rready_o;

  // ********************
  // state register
  // ********************

  always_ff @(posedge clock) begin
    if (reset) begin
      cur_state <= idle;
    end else begin
      cur_state <= next_state;
    end
  end

  // ********************
  // next state
  // ********************

  // one fetch at a time, each step waits for its own handshake
  always_comb begin
    next_state = cur_state;
    case (cur_state)
      idle: begin
        if (valid_pre_i) begin
          next_state = wait_arready;
        end
      end
      wait_arready: begin
        // address accepted by the memory
        if (arready_i) begin
          next_state = wait_rvalid;
        end
      end
      wait_rvalid: begin
        if (rvalid_i) begin
          next_state = wait_ready;
        end
      end
      wait_ready: begin
        // word taken by predecode
        if (ready_post_i) begin
          next_state = idle;
        end
      end
      default: next_state = idle;
    endcase
  end

endmodule

/* hdl/fetch_pkg.sv */
package fetch_pkg;

  // ********************
  // widths
  // ********************

  // pc and instruction word width
  localparam int xlen = 32;

  // register index width, x0..x31
  localparam int reg_addr_w = 5;

  // ********************
  // fetch controller states
  // ********************

  typedef enum logic [1:0] {
    idle,
    wait_arready,
    wait_rvalid,
    wait_ready
  } fetch_state_t;

  // ********************
  // predecode opcode classes
  // ********************

  typedef enum logic [3:0] {
    op_load,
    op_store,
    op_branch,
    op_jal,
    op_jalr,
    op_alu,
    op_alu_imm,
    op_lui,
    op_auipc,
    op_system,
    op_illegal
  } op_class_t;

endpackage

/* hdl/fetch_stage.sv */
`timescale 1ns/100ps

module fetch_stage (
  input  logic                       clock,
  input  logic                       reset,

  // address in from the pc stage
  input  logic                       pc_valid_i,
  output logic                       pc_ready_o,
  input  logic [fetch_pkg::xlen-1:0] pc_i,

  // fetched word out to predecode
  output logic                       inst_valid_o,
  input  logic                       inst_ready_i,
  output logic [fetch_pkg::xlen-1:0] inst_pc_o,
  output logic [fetch_pkg::xlen-1:0] inst_o,

  // address read channel
  output logic [fetch_pkg::xlen-1:0] araddr_o,
  output logic                       arvalid_o,
  input  logic                       arready_i,

  // read data channel
  input  logic [fetch_pkg::xlen-1:0] rdata_i,
  input  logic                       rvalid_i,
  output logic                       rready_o
);

  import fetch_pkg::*;

  logic            pc_we;
  logic            inst_we;
  logic [xlen-1:0] pc_q;
  logic [xlen-1:0] inst_q;

  // ********************
  // sequencing
  // ********************

  fetch_controller u_ctrl (
    .clock        (clock),
    .reset        (reset),
    .valid_pre_i  (pc_valid_i),
    .ready_pre_o  (pc_ready_o),
    .valid_post_o (inst_valid_o),
    .ready_post_i (inst_ready_i),
    .pc_we_o      (pc_we),
    .inst_we_o    (inst_we),
    .arready_i    (arready_i),
    .arvalid_o    (arvalid_o),
    .rready_o     (rready_o),
    .rvalid_i     (rvalid_i)
  );

  // ********************
  // datapath registers
  // ********************

  // pc held from capture until the word leaves
  always_ff @(posedge clock) begin
    if (pc_we) begin
      pc_q <= pc_i;
    end
  end

  // read data held while predecode stalls
  always_ff @(posedge clock) begin
    if (inst_we) begin
      inst_q <= rdata_i;
    end
  end

  // bus address from the held pc, stable while arvalid is up
  assign araddr_o  = pc_q;
  assign inst_pc_o = pc_q;
  assign inst_o    = inst_q;

endmodule

/* hdl/fetch_top.sv */
`timescale 1ns/100ps

module fetch_top #(
  parameter logic [fetch_pkg::xlen-1:0] RESET_PC  = '0,
  parameter int                         MEM_WORDS = 256,
  parameter int                         MAX_DELAY = 3
) (
  input  logic                             clock,
  input  logic                             reset,

  // memory preload
  input  logic                             load_we_i,
  input  logic [$clog2(MEM_WORDS)-1:0]     load_addr_i,
  input  logic [fetch_pkg::xlen-1:0]       load_data_i,

  // predecoded stream
  output logic                             out_valid_o,
  input  logic                             out_ready_i,
  output logic [fetch_pkg::xlen-1:0]       out_pc_o,
  output logic [fetch_pkg::xlen-1:0]       out_inst_o,
  output fetch_pkg::op_class_t             out_class_o,
  output logic [fetch_pkg::reg_addr_w-1:0] out_rd_o
);

  import fetch_pkg::*;

  // pc stage to fetch stage
  logic            pc_valid;
  logic            pc_ready;
  logic [xlen-1:0] pc;

  // fetch stage to predecode
  logic            inst_valid;
  logic            inst_ready;
  logic [xlen-1:0] inst_pc;
  logic [xlen-1:0] inst;

  // memory bus
  logic [xlen-1:0] araddr;
  logic            arvalid;
  logic            arready;
  logic [xlen-1:0] rdata;
  logic            rvalid;
  logic            rready;

  // ********************
  // stages
  // ********************

  pc_stage #(.RESET_PC(RESET_PC)) u_pc (
    .clock      (clock),
    .reset      (reset),
    .pc_valid_o (pc_valid),
    .pc_ready_i (pc_ready),
    .pc_o       (pc)
  );

  fetch_stage u_fetch (
    .clock        (clock),
    .reset        (reset),
    .pc_valid_i   (pc_valid),
    .pc_ready_o   (pc_ready),
    .pc_i         (pc),
    .inst_valid_o (inst_valid),
    .inst_ready_i (inst_ready),
    .inst_pc_o    (inst_pc),
    .inst_o       (inst),
    .araddr_o     (araddr),
    .arvalid_o    (arvalid),
    .arready_i    (arready),
    .rdata_i      (rdata),
    .rvalid_i     (rvalid),
    .rready_o     (rready)
  );

  inst_mem #(
    .MEM_WORDS (MEM_WORDS),
    .MAX_DELAY (MAX_DELAY)
  ) u_mem (
    .clock       (clock),
    .reset       (reset),
    .load_we_i   (load_we_i),
    .load_addr_i (load_addr_i),
    .load_data_i (load_data_i),
    .araddr_i    (araddr),
    .arvalid_i   (arvalid),
    .arready_o   (arready),
    .rdata_o     (rdata),
    .rvalid_o    (rvalid),
    .rready_i    (rready)
  );

  predecode_stage u_predecode (
    .clock       (clock),
    .reset       (reset),
    .in_valid_i  (inst_valid),
    .in_ready_o  (inst_ready),
    .in_pc_i     (inst_pc),
    .in_inst_i   (inst),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_pc_o    (out_pc_o),
    .out_inst_o  (out_inst_o),
    .out_class_o (out_class_o),
    .out_rd_o    (out_rd_o)
  );

endmodule

/* hdl/inst_mem.sv */
`timescale 1ns/100ps

module inst_mem #(
  parameter int MEM_WORDS = 256,
  parameter int MAX_DELAY = 3
) (
  input  logic                         clock,
  input  logic                         reset,

  // preload port, one word per cycle
  input  logic                         load_we_i,
  input  logic [$clog2(MEM_WORDS)-1:0] load_addr_i,
  input  logic [fetch_pkg::xlen-1:0]   load_data_i,

  // address read channel
  input  logic [fetch_pkg::xlen-1:0]   araddr_i,
  input  logic                         arvalid_i,
  output logic                         arready_o,

  // read data channel
  output logic [fetch_pkg::xlen-1:0]   rdata_o,
  output logic                         rvalid_o,
  input  logic                         rready_i
);

  import fetch_pkg::*;

  localparam int idx_w = $clog2(MEM_WORDS);
  localparam int cnt_w = $clog2(MAX_DELAY + 2);

  logic [xlen-1:0]  mem [MEM_WORDS];
  logic [15:0]      lfsr;
  logic [cnt_w-1:0] ar_delay;
  logic [cnt_w-1:0] r_delay;
  logic [cnt_w-1:0] ar_cnt;
  logic [cnt_w-1:0] ar_left;
  logic             ar_armed;
  logic [cnt_w-1:0] r_cnt;
  logic             r_wait;
  logic [idx_w-1:0] rd_idx;
  logic [idx_w-1:0] ar_idx;
  logic             busy;

  // ********************
  // storage
  // ********************

  always_ff @(posedge clock) begin
    if (load_we_i) begin
      mem[load_addr_i] <= load_data_i;
    end
  end

  // word index, wraps modulo the depth
  assign ar_idx = araddr_i[idx_w+1:2];

  // ********************
  // delay source
  // ********************

  // taps 16 14 13 11, maximal length
  always_ff @(posedge clock) begin
    if (reset) begin
      lfsr <= 16'hace1;
    end else begin
      lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
    end
  end

  // separate bytes so the two channels stall independently
  assign ar_delay = cnt_w'(32'(lfsr[7:0]) % (MAX_DELAY + 1));
  assign r_delay  = cnt_w'(32'(lfsr[15:8]) % (MAX_DELAY + 1));

  // ********************
  // address channel
  // ********************

  // one read outstanding at a time
  assign busy = r_wait || rvalid_o;

  // fresh draw on the first cycle of arvalid, then count down
  assign ar_left   = ar_armed ? ar_cnt : ar_delay;
  assign arready_o = arvalid_i && !busy && (ar_left == '0);

  // ********************
  // channel sequencing
  // ********************

  always_ff @(posedge clock) begin
    if (reset) begin
      ar_armed <= 1'b0;
      ar_cnt   <= '0;
      r_wait   <= 1'b0;
      r_cnt    <= '0;
      rvalid_o <= 1'b0;
    end else begin
      if (arready_o) begin
        ar_armed <= 1'b0;
        // zero delay means rvalid on the very next cycle
        if (r_delay == '0) begin
          rvalid_o <= 1'b1;
        end else begin
          r_wait <= 1'b1;
          r_cnt  <= r_delay - 1'b1;
        end
      end else if (arvalid_i && !busy) begin
        ar_armed <= 1'b1;
        ar_cnt   <= ar_left - 1'b1;
      end
      if (r_wait) begin
        if (r_cnt == '0) begin
          r_wait   <= 1'b0;
          rvalid_o <= 1'b1;
        end else begin
          r_cnt <= r_cnt - 1'b1;
        end
      end
      // held until the fetch stage takes it
      if (rvalid_o && rready_i) begin
        rvalid_o <= 1'b0;
      end
    end
  end

  // read index and data, no reset needed on payload
  always_ff @(posedge clock) begin
    if (arready_o) begin
      rd_idx <= ar_idx;
      if (r_delay == '0) begin
        rdata_o <= mem[ar_idx];
      end
    end else if (r_wait && (r_cnt == '0)) begin
      rdata_o <= mem[rd_idx];
    end
  end

endmodule

/* hdl/pc_stage.sv */
`timescale 1ns/100ps

module pc_stage #(
  parameter logic [fetch_pkg::xlen-1:0] RESET_PC = '0
) (
  input  logic                       clock,
  input  logic                       reset,

  // next fetch address towards the fetch stage
  output logic                       pc_valid_o,
  input  logic                       pc_ready_i,
  output logic [fetch_pkg::xlen-1:0] pc_o
);

  import fetch_pkg::*;

  logic            valid_q;
  logic [xlen-1:0] pc_q;
  logic            take;

  // one address handed over
  assign take = valid_q && pc_ready_i;

  // ********************
  // counter
  // ********************

  // valid comes up the first cycle after reset and stays up,
  // there is always a next sequential address to offer
  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q <= 1'b0;
      pc_q    <= RESET_PC;
    end else begin
      valid_q <= 1'b1;
      // step one word per accepted address, stays aligned
      if (take) begin
        pc_q <= pc_q + xlen'(4);
      end
    end
  end

  assign pc_valid_o = valid_q;
  assign pc_o       = pc_q;

endmodule

/* hdl/predecode_stage.sv */
`timescale 1ns/100ps

module predecode_stage (
  input  logic                             clock,
  input  logic                             reset,

  // fetched word from the fetch stage
  input  logic                             in_valid_i,
  output logic                             in_ready_o,
  input  logic [fetch_pkg::xlen-1:0]       in_pc_i,
  input  logic [fetch_pkg::xlen-1:0]       in_inst_i,

  // tagged word downstream
  output logic                             out_valid_o,
  input  logic                             out_ready_i,
  output logic [fetch_pkg::xlen-1:0]       out_pc_o,
  output logic [fetch_pkg::xlen-1:0]       out_inst_o,
  output fetch_pkg::op_class_t             out_class_o,
  output logic [fetch_pkg::reg_addr_w-1:0] out_rd_o
);

  import fetch_pkg::*;

  op_class_t             cls;
  logic [reg_addr_w-1:0] rd;
  logic                  load;

  // ********************
  // classification
  // ********************

  // RV32I major opcodes, low two bits must be 11
  function automatic op_class_t classify(input logic [6:0] opcode);
    op_class_t c;
    case (opcode)
      7'b0000011: c = op_load;
      7'b0100011: c = op_store;
      7'b1100011: c = op_branch;
      7'b1101111: c = op_jal;
      7'b1100111: c = op_jalr;
      7'b0110011: c = op_alu;
      7'b0010011: c = op_alu_imm;
      7'b0110111: c = op_lui;
      7'b0010111: c = op_auipc;
      7'b1110011: c = op_system;
      default:    c = op_illegal;
    endcase
    return c;
  endfunction

  assign cls = classify(in_inst_i[6:0]);

  // no destination for store, branch, illegal
  assign rd = (cls == op_store || cls == op_branch || cls == op_illegal) ?
              '0 : in_inst_i[11:7];

  // ********************
  // pipeline register
  // ********************

  // empty, or the held entry leaves this cycle
  assign in_ready_o = !out_valid_o || out_ready_i;
  assign load       = in_valid_i && in_ready_o;

  always_ff @(posedge clock) begin
    if (reset) begin
      out_valid_o <= 1'b0;
    end else if (load) begin
      out_valid_o <= 1'b1;
    end else if (out_ready_i) begin
      out_valid_o <= 1'b0;
    end
  end

  // payload only changes on a load, so it holds under stall
  always_ff @(posedge clock) begin
    if (load) begin
      out_pc_o    <= in_pc_i;
      out_inst_o  <= in_inst_i;
      out_class_o <= cls;
      out_rd_o    <= rd;
    end
  end

endmodule

/* project.f */
hdl/fetch_pkg.sv
hdl/pc_stage.sv
hdl/fetch_controller.sv
hdl/fetch_stage.sv
hdl/inst_mem.sv
hdl/predecode_stage.sv
hdl/fetch_top.sv
tests/fetch_sva.sv
tests/fetch_tb.sv

/* tests/fetch_sva.sv */
`timescale 1ns/100ps

module fetch_sva (
  input logic                       clock,
  input logic                       reset,
  input logic                       arvalid_i,
  input logic                       arready_i,
  input logic [fetch_pkg::xlen-1:0] araddr_i,
  input logic                       rvalid_i,
  input logic                       rready_i,
  input logic                       pc_we_i,
  input logic                       inst_valid_i,
  input logic                       inst_ready_i,
  input fetch_pkg::fetch_state_t    state_i
);

  import fetch_pkg::*;

  // fetch in flight, pc capture to downstream transfer
  logic fetch_busy;
  // read outstanding, address transfer to data transfer
  logic rd_pending;

  // ********************
  // bus side tracking
  // ********************

  always_ff @(posedge clock) begin
    if (reset) begin
      fetch_busy <= 1'b0;
      rd_pending <= 1'b0;
    end else begin
      if (pc_we_i) begin
        fetch_busy <= 1'b1;
      end else if (inst_valid_i && inst_ready_i) begin
        fetch_busy <= 1'b0;
      end
      if (arvalid_i && arready_i) begin
        rd_pending <= 1'b1;
      end else if (rvalid_i && rready_i) begin
        rd_pending <= 1'b0;
      end
    end
  end

  // ********************
  // bus handshake
  // ********************

  // request and its address held until accepted
  a_ar_hold: assert property (@(posedge clock) disable iff (reset)
    arvalid_i && !arready_i |=> arvalid_i && $stable(araddr_i))
    else $error("arvalid dropped or araddr moved before arready");

  // read data held until taken
  a_r_hold: assert property (@(posedge clock) disable iff (reset)
    rvalid_i && !rready_i |=> rvalid_i)
    else $error("rvalid dropped before rready");

  // ********************
  // controller
  // ********************

  // rready only between address accept and data transfer
  a_rready_state: assert property (@(posedge clock) disable iff (reset)
    rready_i |-> rd_pending)
    else $error("rready high outside wait_rvalid");

  // new pc only taken once the previous word has left
  a_pc_idle: assert property (@(posedge clock) disable iff (reset)
    pc_we_i |-> !fetch_busy)
    else $error("pc captured while a fetch was still in flight");

  // idle means nothing left on the bus or downstream
  a_idle_clear: assert property (@(posedge clock) disable iff (reset)
    state_i == idle |-> !fetch_busy && !rd_pending)
    else $error("controller idle with a fetch still in flight");

endmodule

bind fetch_stage fetch_sva u_sva (
  .clock        (clock),
  .reset        (reset),
  .arvalid_i    (arvalid_o),
  .arready_i    (arready_i),
  .araddr_i     (araddr_o),
  .rvalid_i     (rvalid_i),
  .rready_i     (rready_o),
  .pc_we_i      (pc_we),
  .inst_valid_i (inst_valid_o),
  .inst_ready_i (inst_ready_i),
  .state_i      (u_ctrl.cur_state)
);

/* tests/fetch_tb.sv */
`timescale 1ns/100ps

module fetch_tb;

  import fetch_pkg::*;

  localparam logic [xlen-1:0] reset_pc = 32'h0000_0014;
  // depth fits inside the reset window, one load per cycle
  localparam int mem_words    = 8;
  localparam int max_delay    = 3;
  localparam int idx_w        = $clog2(mem_words);
  localparam int reset_cycles = 8;
  localparam int num_words    = 300;
  localparam int max_cycles   = 20000;

  logic                  clock;
  logic                  reset;
  logic                  load_we;
  logic [idx_w-1:0]      load_addr;
  logic [xlen-1:0]       load_data;
  logic                  out_valid;
  logic                  out_ready;
  logic [xlen-1:0]       out_pc;
  logic [xlen-1:0]       out_inst;
  op_class_t             out_class;
  logic [reg_addr_w-1:0] out_rd;

  integer          seed;
  int              errors;
  int              received;
  int              illegal_seen;
  logic [xlen-1:0] exp_pc;
  // model copy of the instruction memory
  logic [xlen-1:0] model_mem [mem_words];

  fetch_top #(
    .RESET_PC  (reset_pc),
    .MEM_WORDS (mem_words),
    .MAX_DELAY (max_delay)
  ) u_dut (
    .clock       (clock),
    .reset       (reset),
    .load_we_i   (load_we),
    .load_addr_i (load_addr),
    .load_data_i (load_data),
    .out_valid_o (out_valid),
    .out_ready_i (out_ready),
    .out_pc_o    (out_pc),
    .out_inst_o  (out_inst),
    .out_class_o (out_class),
    .out_rd_o    (out_rd)
  );

  // ********************
  // model
  // ********************

  // RV32I major opcodes, picked by number
  function automatic logic [6:0] pick_opcode(input int n);
    logic [6:0] op;
    case (n)
      0:       op = 7'b0000011;
      1:       op = 7'b0100011;
      2:       op = 7'b1100011;
      3:       op = 7'b1101111;
      4:       op = 7'b1100111;
      5:       op = 7'b0110011;
      6:       op = 7'b0010011;
      7:       op = 7'b0110111;
      8:       op = 7'b0010111;
      default: op = 7'b1110011;
    endcase
    return op;
  endfunction

  // low bits first, then the five opcode bits above them
  function automatic op_class_t expect_class(input logic [xlen-1:0] w);
    op_class_t c;
    c = op_illegal;
    if (w[1:0] == 2'b11) begin
      case (w[6:2])
        5'b00000: c = op_load;
        5'b01000: c = op_store;
        5'b11000: c = op_branch;
        5'b11011: c = op_jal;
        5'b11001: c = op_jalr;
        5'b01100: c = op_alu;
        5'b00100: c = op_alu_imm;
        5'b01101: c = op_lui;
        5'b00101: c = op_auipc;
        5'b11100: c = op_system;
        default:  c = op_illegal;
      endcase
    end
    return c;
  endfunction

  // rd field, zero where the class writes no register
  function automatic logic [reg_addr_w-1:0] expect_rd(input logic [xlen-1:0] w);
    op_class_t c;
    c = expect_class(w);
    if (c == op_store || c == op_branch || c == op_illegal) begin
      return '0;
    end
    return w[11:7];
  endfunction

  // even index carries an opcode, odd index is junk
  task automatic make_word(input int index, output logic [xlen-1:0] word);
    word = $random(seed);
    if (index % 2 == 0) begin
      word[6:0] = pick_opcode($unsigned($random(seed)) % 10);
    end else begin
      // bit 0 clear, never a valid opcode
      word[0] = 1'b0;
    end
  endtask

  task automatic check_value(input string what, input logic [xlen-1:0] got,
                             input logic [xlen-1:0] expected);
    if (got !== expected) begin
      errors++;
      $display("FAIL %0t ns: %s, got %h expected %h", $time, what, got, expected);
    end
  endtask

  // ********************
  // clock
  // ********************

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  // ********************
  // stimulus
  // ********************

  initial begin
    int              cycles;
    logic [xlen-1:0] word;
    seed         = 38845;
    errors       = 0;
    received     = 0;
    illegal_seen = 0;
    exp_pc       = reset_pc;
    reset        = 1'b1;
    load_we      = 1'b0;
    load_addr    = '0;
    load_data    = '0;
    out_ready    = 1'b0;
    // preload one word per reset cycle
    for (int i = 0; i < reset_cycles; i++) begin
      if (i < mem_words) begin
        make_word(i, word);
        load_we      = 1'b1;
        load_addr    = idx_w'(i);
        load_data    = word;
        model_mem[i] = word;
      end else begin
        load_we = 1'b0;
      end
      @(posedge clock);
      #1;
    end
    load_we = 1'b0;
    reset   = 1'b0;
    // random back-pressure until enough words are out
    cycles = 0;
    while (received < num_words && cycles < max_cycles) begin
      out_ready = ($random(seed) & 3) != 0;
      @(posedge clock);
      #1;
      cycles++;
    end
    if (received < num_words) begin
      $display("timeout: only %0d of %0d words came out", received, num_words);
      errors++;
    end
    check_value("illegal words seen", 32'(illegal_seen != 0), 32'd1);
    $display("errors: %0d, words checked: %0d", errors, received);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // ********************
  // monitor
  // ********************

  // negedge sampling, inputs and outputs both settled
  initial begin
    int                    low_cycles;
    logic                  stalled;
    logic [xlen-1:0]       held_pc;
    logic [xlen-1:0]       held_inst;
    op_class_t             held_class;
    logic [reg_addr_w-1:0] held_rd;
    logic [xlen-1:0]       word;
    low_cycles = 0;
    stalled    = 1'b0;
    forever begin
      @(negedge clock);
      if (reset) begin
        check_value("out_valid during reset", 32'(out_valid), 32'd0);
      end else begin
        low_cycles++;
        // second low negedge is the first cycle the DUT runs
        if (low_cycles <= 2) begin
          check_value("out_valid right after reset", 32'(out_valid), 32'd0);
        end
      end
      // stalled last cycle, everything must hold
      if (stalled) begin
        check_value("out_valid under stall", 32'(out_valid), 32'd1);
        check_value("out_pc under stall", out_pc, held_pc);
        check_value("out_inst under stall", out_inst, held_inst);
        check_value("out_class under stall", 32'(out_class), 32'(held_class));
        check_value("out_rd under stall", 32'(out_rd), 32'(held_rd));
      end
      stalled    = !reset && out_valid && !out_ready;
      held_pc    = out_pc;
      held_inst  = out_inst;
      held_class = out_class;
      held_rd    = out_rd;
      // transfer at the coming edge
      if (!reset && out_valid && out_ready) begin
        word = model_mem[exp_pc[idx_w+1:2]];
        check_value("out_pc order", out_pc, exp_pc);
        check_value("out_inst data", out_inst, word);
        check_value("out_class", 32'(out_class), 32'(expect_class(word)));
        check_value("out_rd", 32'(out_rd), 32'(expect_rd(word)));
        // tagged illegal by the DUT itself
        if (out_class == op_illegal) begin
          illegal_seen++;
        end
        exp_pc = exp_pc + 32'd4;
        received++;
      end
    end
  end

endmodule
